// ==== src/dmm_pkg.sv ====
/*
  shared definitions for the multimeter control core
  - register width, address byte and spi frame length
  - register map and status magic byte
  - output mode and sequencer state enums
  - bit positions and field widths of the 25-bit output word
*/

package dmm_pkg;

  ////////////////////////////////////////
  // spi register bank

  localparam int REG_WIDTH  = 32;
  localparam int ADDR_WIDTH = 8;
  localparam int FRAME_BITS = ADDR_WIDTH + REG_WIDTH; // addr first, msb first

  localparam logic [ADDR_WIDTH-1:0] REG_SPI_MUX   = 8'd1;
  localparam logic [ADDR_WIDTH-1:0] REG_4094      = 8'd2;
  localparam logic [ADDR_WIDTH-1:0] REG_MODE      = 8'd3;
  localparam logic [ADDR_WIDTH-1:0] REG_DIRECT    = 8'd4;
  localparam logic [ADDR_WIDTH-1:0] REG_STATUS    = 8'd5; // read only
  localparam logic [ADDR_WIDTH-1:0] REG_APERTURE  = 8'd6;
  localparam logic [ADDR_WIDTH-1:0] REG_PRECHARGE = 8'd7;

  localparam logic [7:0] STATUS_MAGIC = 8'hAA; // low byte of status

  ////////////////////////////////////////
  // modes and sequencer

  typedef enum logic [2:0] {
    MODE_DIRECT  = 3'd0,
    MODE_ZERO    = 3'd1,
    MODE_ONES    = 3'd2,
    MODE_PATTERN = 3'd3,
    MODE_SA      = 3'd4,
    MODE_SPARE5  = 3'd5,
    MODE_SPARE6  = 3'd6,
    MODE_SPARE7  = 3'd7
  } mode_e;

  typedef enum logic [1:0] {
    SA_IDLE      = 2'd0,
    SA_PRECHARGE = 2'd1,
    SA_SAMPLE    = 2'd2
  } sa_state_e;

  localparam int PC_WIDTH = 24; // precharge count, low bits of register

  ////////////////////////////////////////
  // output word layout

  localparam int OUT_WIDTH    = 25;
  localparam int OUT_LEDS     = 0;
  localparam int LEDS_WIDTH   = 4;
  localparam int OUT_MONITOR  = 4;
  localparam int MON_WIDTH    = 8;
  localparam int OUT_SPI_INT  = 12;
  localparam int OUT_MEAS     = 13;
  localparam int OUT_PC1      = 14;
  localparam int OUT_PC2      = 15;
  localparam int OUT_AZMUX    = 16;
  localparam int AZMUX_WIDTH  = 4;
  localparam int OUT_CMPR     = 20;
  localparam int OUT_REFMUX   = 21;
  localparam int REFMUX_WIDTH = 4;

endpackage

// ==== src/spi_regs.sv ====
/*
  spi slave register bank
  - 40-bit frames, 8 address bits then 32 data bits, msb first
  - write commits on deselect, only for complete frames
  - data phase returns the value held before the frame
  - status word built from the hw flags and the magic byte
*/

`timescale 1ns/1ps

module spi_regs (
  input  logic                          spi_sck_i,
  input  logic                          arst_n_i,
  input  logic                          spi_ss_n_i,
  input  logic                          spi_mosi_i,
  input  logic [2:0]                    hw_flags_i,
  output logic                          spi_dout_o,
  output logic [dmm_pkg::REG_WIDTH-1:0] reg_spi_mux_o,
  output logic [dmm_pkg::REG_WIDTH-1:0] reg_4094_o,
  output logic [dmm_pkg::REG_WIDTH-1:0] reg_mode_o,
  output logic [dmm_pkg::REG_WIDTH-1:0] reg_direct_o,
  output logic [dmm_pkg::REG_WIDTH-1:0] reg_aperture_o,
  output logic [dmm_pkg::REG_WIDTH-1:0] reg_precharge_o
);

  import dmm_pkg::*;

  logic                  frame_rst_n;  // low while deselected or in reset
  logic [5:0]            bit_cnt_q;    // bits clocked this frame
  logic [FRAME_BITS-1:0] shift_in_q;
  logic [REG_WIDTH-1:0]  dout_sr_q;
  logic [REG_WIDTH-1:0]  rd_word;
  logic [ADDR_WIDTH-1:0] wr_addr;
  logic [REG_WIDTH-1:0]  wr_data;

  assign frame_rst_n = arst_n_i & ~spi_ss_n_i;
  assign wr_addr     = shift_in_q[FRAME_BITS-1 -: ADDR_WIDTH];
  assign wr_data     = shift_in_q[REG_WIDTH-1:0];
  assign spi_dout_o  = dout_sr_q[REG_WIDTH-1];

  ////////////////////////////////////////
  // capture, rising sck

  always_ff @(posedge spi_sck_i or negedge frame_rst_n) begin
    if (!frame_rst_n) begin
      bit_cnt_q <= '0;
    end else if (bit_cnt_q != '1) begin  // saturate on overlong frames
      bit_cnt_q <= bit_cnt_q + 1'b1;
    end
  end

  always_ff @(posedge spi_sck_i) begin
    shift_in_q <= {shift_in_q[FRAME_BITS-2:0], spi_mosi_i};
  end

  // address sits in the low byte after 8 bits
  always_comb begin
    case (shift_in_q[ADDR_WIDTH-1:0])
      REG_SPI_MUX:   rd_word = reg_spi_mux_o;
      REG_4094:      rd_word = reg_4094_o;
      REG_MODE:      rd_word = reg_mode_o;
      REG_DIRECT:    rd_word = reg_direct_o;
      REG_STATUS:    rd_word = {{(REG_WIDTH - ADDR_WIDTH - 3){1'b0}}, hw_flags_i, STATUS_MAGIC};
      REG_APERTURE:  rd_word = reg_aperture_o;
      REG_PRECHARGE: rd_word = reg_precharge_o;
      default:       rd_word = '0; // unknown reads zero
    endcase
  end

  ////////////////////////////////////////
  // read-back, falling sck

  always_ff @(negedge spi_sck_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      dout_sr_q <= '0;
    end else if (bit_cnt_q == ADDR_WIDTH) begin
      dout_sr_q <= rd_word;                                 // msb ready before bit 9
    end else if (bit_cnt_q > ADDR_WIDTH) begin
      dout_sr_q <= {dout_sr_q[REG_WIDTH-2:0], 1'b0};
    end
  end

  ////////////////////////////////////////
  // commit on deselect

  always_ff @(posedge spi_ss_n_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      reg_spi_mux_o   <= '0;
      reg_4094_o      <= '0;
      reg_mode_o      <= '0;
      reg_direct_o    <= '0;
      reg_aperture_o  <= '0;
      reg_precharge_o <= '0;
    end else if (bit_cnt_q == FRAME_BITS) begin  // full frames only
      case (wr_addr)
        REG_SPI_MUX:   reg_spi_mux_o   <= wr_data;
        REG_4094:      reg_4094_o      <= wr_data;
        REG_MODE:      reg_mode_o      <= wr_data;
        REG_DIRECT:    reg_direct_o    <= wr_data;
        REG_APERTURE:  reg_aperture_o  <= wr_data;
        REG_PRECHARGE: reg_precharge_o <= wr_data;
        default: ;                                  // status and unknown dropped
      endcase
    end
  end

  // master clocks no more than one frame per select
  a_frame_len: assert property (@(posedge spi_sck_i) disable iff (!arst_n_i)
    !spi_ss_n_i |-> bit_cnt_q < FRAME_BITS);

endmodule

// ==== src/spi_route.sv ====
/*
  spi routing
  - second chip select passes sck and mosi to the 4094 chain
  - 4094 strobe held high while routed
  - miso priority, register bank then 4094 chain
*/

`timescale 1ns/1ps

module spi_route (
  input  logic spi_sck_i,
  input  logic spi_mosi_i,
  input  logic spi_cs2_i,
  input  logic spi_ss_n_i,
  input  logic route_en_i,        // spi mux register bit 0
  input  logic reg_dout_i,
  input  logic u1004_4094_data_i,
  output logic glb_4094_clk_o,
  output logic glb_4094_data_o,
  output logic glb_4094_strobe_o,
  output logic spi_miso_o
);

  logic route_act;

  // cs2 is active low
  assign route_act = route_en_i & ~spi_cs2_i;

  // all three lines parked low when not routed
  assign glb_4094_clk_o    = route_act & spi_sck_i;
  assign glb_4094_data_o   = route_act & spi_mosi_i;
  assign glb_4094_strobe_o = route_act;  // strobe hi, latch follows shift

  always_comb begin
    if (!spi_ss_n_i) begin
      spi_miso_o = reg_dout_i;          // register bank wins
    end else if (route_act) begin
      spi_miso_o = u1004_4094_data_i;   // chain read-back
    end else begin
      spi_miso_o = 1'b0;
    end
  end

endmodule

// ==== src/sa_timer.sv ====
/*
  phase timer for the acquisition sequencer
  - loadable down-counter, zero count runs as one cycle
  - one-cycle expiry pulse on the last cycle, reload from count_i
*/

`timescale 1ns/1ps

module sa_timer (
  input  logic        clk,
  input  logic        arst_n_i,
  input  logic        load_i,
  input  logic [31:0] count_i,
  output logic        expire_o
);

  logic [31:0] cnt_q;
  logic [31:0] count_eff;

  assign count_eff = (count_i == '0) ? 32'd1 : count_i;
  assign expire_o  = (cnt_q == 32'd1);  // last cycle of phase

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      cnt_q <= '0;                          // idle, no pulse
    end else if (load_i || expire_o) begin
      cnt_q <= count_eff;                   // next phase starts next cycle
    end else if (cnt_q != '0) begin
      cnt_q <= cnt_q - 1'b1;
    end
  end

  // sequencer only loads from idle, never mid-phase
  a_no_load_on_expire: assert property (@(posedge clk) disable iff (!arst_n_i)
    !(expire_o && load_i));

endmodule

// ==== src/sa_fsm.sv ====
/*
  precharge / sample acquisition sequencer
  - alternates precharge and sample phases off the phase timer
  - drives the precharge switch, a led and the monitor byte
*/

`timescale 1ns/1ps

module sa_fsm (
  input  logic                        clk,
  input  logic                        arst_n_i,
  input  logic [31:0]                 aperture_i,
  input  logic [dmm_pkg::PC_WIDTH-1:0] precharge_i,
  output logic                        sw_pc_o,
  output logic                        led_o,
  output logic [7:0]                  monitor_o
);

  import dmm_pkg::*;

  sa_state_e   state_q;
  sa_state_e   state_d;
  logic        expire;
  logic        load;
  logic [31:0] next_count;
  logic [5:0]  cycles_q;  // completed precharge/sample periods, wraps

  // count for the phase that follows the current one
  assign next_count = (state_q == SA_PRECHARGE) ? aperture_i
                                                : {{(32 - PC_WIDTH){1'b0}}, precharge_i};
  assign load = (state_q == SA_IDLE);  // first load only, then timer reloads

  sa_timer sa_timer_i (
    .clk      (clk),
    .arst_n_i (arst_n_i),
    .load_i   (load),
    .count_i  (next_count),
    .expire_o (expire)
  );

  always_comb begin
    state_d = state_q;
    case (state_q)
      SA_IDLE:      state_d = SA_PRECHARGE;
      SA_PRECHARGE: if (expire) state_d = SA_SAMPLE;
      SA_SAMPLE:    if (expire) state_d = SA_PRECHARGE;
      default:      state_d = SA_IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q  <= SA_IDLE;
      led_o    <= 1'b0;
      cycles_q <= '0;
    end else begin
      state_q <= state_d;
      if (state_q == SA_SAMPLE && expire) begin  // end of sample
        led_o    <= ~led_o;
        cycles_q <= cycles_q + 1'b1;
      end
    end
  end

  assign sw_pc_o   = (state_q == SA_SAMPLE);  // switch closed to sample
  assign monitor_o = {cycles_q, state_q};

  // a precharge count of 0 or 1 ends the phase in its first cycle
  a_short_precharge: assert property (@(posedge clk) disable iff (!arst_n_i)
    ($changed(state_q) && state_q == SA_PRECHARGE && precharge_i <= 1) |-> expire);

endmodule

// ==== src/output_mode.sv ====
/*
  output word mode select
  - free-running test pattern counter
  - eight-way select of the 25 control pins by mode
*/

`timescale 1ns/1ps

module output_mode (
  input  logic                          clk,
  input  logic                          arst_n_i,
  input  logic [2:0]                    mode_i,
  input  logic [dmm_pkg::REG_WIDTH-1:0] direct_i,
  input  logic                          sa_sw_pc_i,
  input  logic                          sa_led_i,
  input  logic [7:0]                    sa_monitor_i,
  output logic [dmm_pkg::OUT_WIDTH-1:0] out_o
);

  import dmm_pkg::*;

  logic [REG_WIDTH-1:0] pattern_q;
  mode_e                mode;

  assign mode = mode_e'(mode_i);

  // test pattern, counts every clock from reset
  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      pattern_q <= '0;
    end else begin
      pattern_q <= pattern_q + 1'b1;
    end
  end

  always_comb begin
    out_o = '0;
    case (mode)
      MODE_DIRECT:  out_o = direct_i[OUT_WIDTH-1:0];  // default after reset
      MODE_ZERO:    out_o = '0;
      MODE_ONES:    out_o = '1;
      MODE_PATTERN: out_o = pattern_q[OUT_WIDTH-1:0];
      MODE_SA: begin
        out_o[OUT_LEDS]                    = sa_led_i;
        out_o[OUT_MONITOR +: MON_WIDTH]    = sa_monitor_i;
        out_o[OUT_PC1]                     = sa_sw_pc_i;
      end
      default:      out_o = '0;  // spare modes
    endcase
  end

endmodule

// ==== src/dmm_top.sv ====
/*
  multimeter control core, top level
  - spi register bank and 4094 routing
  - acquisition sequencer and output mode select
  - output word sliced onto the front-end pins
*/

`timescale 1ns/1ps

module dmm_top (
  input  logic       clk,
  input  logic       arst_n_i,
  input  logic       spi_sck_i,
  input  logic       spi_mosi_i,
  input  logic       spi_ss_n_i,
  input  logic       spi_cs2_i,
  output logic       spi_miso_o,
  input  logic [2:0] hw_flags_i,
  input  logic       u1004_4094_data_i,
  output logic       glb_4094_data_o,
  output logic       glb_4094_clk_o,
  output logic       glb_4094_oe_o,
  output logic       glb_4094_strobe_o,
  output logic [3:0] leds_o,
  output logic [7:0] monitor_o,
  output logic       spi_interrupt_ctl_o,
  output logic       meas_complete_o,
  output logic       sig_pc1_sw_o,
  output logic       sig_pc2_sw_o,
  output logic [3:0] azmux_o,
  output logic       cmpr_latch_o,
  output logic [3:0] refmux_o
);

  import dmm_pkg::*;

  logic [REG_WIDTH-1:0] reg_spi_mux, reg_4094, reg_mode, reg_direct;
  logic [REG_WIDTH-1:0] reg_aperture, reg_precharge;
  logic                 reg_dout;                  // bank miso, muxed below
  logic                 sa_sw_pc, sa_led;
  logic [7:0]           sa_monitor;
  logic [OUT_WIDTH-1:0] out_w;

  ////////////////////////////////////////
  // spi side, sck domain

  spi_regs spi_regs_i (
    .spi_sck_i       (spi_sck_i),
    .arst_n_i        (arst_n_i),
    .spi_ss_n_i      (spi_ss_n_i),
    .spi_mosi_i      (spi_mosi_i),
    .hw_flags_i      (hw_flags_i),
    .spi_dout_o      (reg_dout),
    .reg_spi_mux_o   (reg_spi_mux),
    .reg_4094_o      (reg_4094),
    .reg_mode_o      (reg_mode),
    .reg_direct_o    (reg_direct),
    .reg_aperture_o  (reg_aperture),
    .reg_precharge_o (reg_precharge)
  );

  spi_route spi_route_i (
    .spi_sck_i         (spi_sck_i),
    .spi_mosi_i        (spi_mosi_i),
    .spi_cs2_i         (spi_cs2_i),
    .spi_ss_n_i        (spi_ss_n_i),
    .route_en_i        (reg_spi_mux[0]),
    .reg_dout_i        (reg_dout),
    .u1004_4094_data_i (u1004_4094_data_i),
    .glb_4094_clk_o    (glb_4094_clk_o),
    .glb_4094_data_o   (glb_4094_data_o),
    .glb_4094_strobe_o (glb_4094_strobe_o),
    .spi_miso_o        (spi_miso_o)
  );

  assign glb_4094_oe_o = reg_4094[0];  // lo from reset, chain disabled

  ////////////////////////////////////////
  // system clock side, registers quasi-static

  sa_fsm sa_fsm_i (
    .clk         (clk),
    .arst_n_i    (arst_n_i),
    .aperture_i  (reg_aperture),
    .precharge_i (reg_precharge[PC_WIDTH-1:0]),
    .sw_pc_o     (sa_sw_pc),
    .led_o       (sa_led),
    .monitor_o   (sa_monitor)
  );

  output_mode output_mode_i (
    .clk          (clk),
    .arst_n_i     (arst_n_i),
    .mode_i       (reg_mode[2:0]),
    .direct_i     (reg_direct),
    .sa_sw_pc_i   (sa_sw_pc),
    .sa_led_i     (sa_led),
    .sa_monitor_i (sa_monitor),
    .out_o        (out_w)
  );

  // pin slices
  assign leds_o              = out_w[OUT_LEDS +: LEDS_WIDTH];
  assign monitor_o           = out_w[OUT_MONITOR +: MON_WIDTH];
  assign spi_interrupt_ctl_o = out_w[OUT_SPI_INT];
  assign meas_complete_o     = out_w[OUT_MEAS];
  assign sig_pc1_sw_o        = out_w[OUT_PC1];
  assign sig_pc2_sw_o        = out_w[OUT_PC2];
  assign azmux_o             = out_w[OUT_AZMUX +: AZMUX_WIDTH];
  assign cmpr_latch_o        = out_w[OUT_CMPR];
  assign refmux_o            = out_w[OUT_REFMUX +: REFMUX_WIDTH];  // top of word

endmodule

// ==== test/tb_clock.sv ====
/*
  testbench clock and reset
  - 100 ns system clock
  - reset low for the first 2 cycles, released on a falling edge
*/

`timescale 1ns/1ps

module tb_clock (
  output logic clk_o,
  output logic arst_n_o
);

  initial begin
    clk_o = 1'b0;
    forever #50 clk_o = ~clk_o;  // 100 ns period
  end

  initial begin
    arst_n_o = 1'b0;
    repeat (2) @(negedge clk_o);
    arst_n_o = 1'b1;  // away from the rising edge
  end

endmodule

// ==== test/tb_dmm.sv ====
/*
  testbench for the multimeter control core
  - spi frame task with read-back, lcg for random words
  - reference model of the output word and a compare process
  - reset, read-back, static modes, pattern, sequencer, 4094 routing
  - cycle timeout
*/

`timescale 1ns/1ps

module tb_dmm;

  // about 40 frames of ~330 clocks plus the hold and sequencer cycles
  localparam int MAX_CYCLES = 20000;

  logic        clk, arst_n;
  logic        spi_sck, spi_mosi, spi_ss_n, spi_cs2, u1004_data;
  logic [2:0]  hw_flags;
  logic        miso, g_data, g_clk, g_oe, g_strobe;
  logic [3:0]  leds, azmux, refmux;
  logic [7:0]  monitor;
  logic        spi_int, meas, pc1_sw, pc2_sw, cmpr;
  logic [24:0] pins;               // pins packed back into the output word

  int          errors = 0;
  int          cycles = 0;
  logic        static_chk = 1'b0;  // compare process enable
  logic [2:0]  model_mode = 3'd0;
  logic [31:0] model_direct = '0;
  logic [31:0] rng_state = 32'hc33cff32;
  logic [7:0]  rb_addr [3];
  logic [31:0] rb_prev [3];        // last value written per register
  logic [2:0]  smodes [6];

  tb_clock tb_clock_i (.clk_o(clk), .arst_n_o(arst_n));

  dmm_top dut_i (
    .clk (clk), .arst_n_i (arst_n),
    .spi_sck_i (spi_sck), .spi_mosi_i (spi_mosi), .spi_ss_n_i (spi_ss_n),
    .spi_cs2_i (spi_cs2), .spi_miso_o (miso), .hw_flags_i (hw_flags),
    .u1004_4094_data_i (u1004_data),
    .glb_4094_data_o (g_data), .glb_4094_clk_o (g_clk), .glb_4094_oe_o (g_oe),
    .glb_4094_strobe_o (g_strobe),
    .leds_o (leds), .monitor_o (monitor), .spi_interrupt_ctl_o (spi_int),
    .meas_complete_o (meas), .sig_pc1_sw_o (pc1_sw), .sig_pc2_sw_o (pc2_sw),
    .azmux_o (azmux), .cmpr_latch_o (cmpr), .refmux_o (refmux)
  );

  assign pins = {refmux, cmpr, azmux, pc2_sw, pc1_sw, meas, spi_int, monitor, leds};

  ////////////////////////////////////////
  // helpers

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // output word from mode and direct register, static modes only
  function automatic logic [24:0] expected_out(input logic [2:0] mode, input logic [31:0] direct);
    logic [24:0] w;
    case (mode)
      3'd0:    w = direct[24:0];  // direct drive
      3'd2:    w = '1;            // all ones
      default: w = '0;            // zeros and spares
    endcase
    return w;
  endfunction

  task automatic check_equal(input logic [31:0] got, input logic [31:0] exp, input string what);
    assert (got === exp) else begin
      errors++;
      $display("FAILED at %0t: %s, got %h, expected %h", $time, what, got, exp);
    end
  endtask

  // one 40-bit frame, mode 0, 4 system clocks per half period
  task automatic spi_xfer(input logic [7:0] addr, input logic [31:0] wdata,
                          output logic [31:0] rdata);
    logic [39:0] frame;
    frame = {addr, wdata};
    rdata = '0;
    @(negedge clk);
    spi_ss_n = 1'b0;
    for (int i = 39; i >= 0; i--) begin
      spi_mosi = frame[i];
      spi_sck  = 1'b0;
      repeat (4) @(negedge clk);
      if (i < 32) rdata = {rdata[30:0], miso};  // sample just before rising sck
      spi_sck = 1'b1;
      repeat (4) @(negedge clk);
    end
    spi_sck = 1'b0;
    repeat (4) @(negedge clk);
    spi_ss_n = 1'b1;  // commit
    repeat (2) @(negedge clk);
  endtask

  task automatic write_reg(input logic [7:0] addr, input logic [31:0] data);
    logic [31:0] unused_rd;
    spi_xfer(addr, data, unused_rd);
  endtask

  // one sequencer sample, unused pins checked on the way
  task automatic sa_sample(output logic pc1, output logic led);
    @(negedge clk);
    pc1 = pc1_sw;
    led = leds[0];
    check_equal({leds[3:1], spi_int, meas, pc2_sw, azmux, cmpr, refmux}, '0,
                "unused pins in sequencer mode");
    check_equal(monitor[1:0], pc1 ? 32'd2 : 32'd1, "sequencer state code on monitor");
  endtask

  task automatic route_check(input logic sck, input logic mosi, input logic chain,
                             input logic active);
    @(negedge clk);
    spi_sck    = sck;
    spi_mosi   = mosi;
    u1004_data = chain;
    @(posedge clk);  // combinational, settled half a cycle later
    check_equal(g_clk, active & sck, "4094 clock");
    check_equal(g_data, active & mosi, "4094 data");
    check_equal(g_strobe, active, "4094 strobe");
    check_equal(miso, active & chain, "miso from 4094 chain");
  endtask

  task automatic finish_run(input logic timed_out);
    $display("errors: %0d", errors);
    if (errors == 0 && !timed_out) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  endtask

  ////////////////////////////////////////
  // compare process and timeout

  always @(negedge clk) begin
    if (static_chk) begin
      assert (pins === expected_out(model_mode, model_direct)) else begin
        errors++;
        $display("FAILED at %0t: pins %h, expected %h in mode %0d", $time, pins,
                 expected_out(model_mode, model_direct), model_mode);
      end
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles >= MAX_CYCLES) begin
      $display("timeout, the tests did not finish within %0d clock cycles", MAX_CYCLES);
      finish_run(1'b1);
    end
  end

  ////////////////////////////////////////
  // stimulus

  initial begin
    logic [31:0] rd, w;
    logic        pc1, led, led_ref;
    logic [3:0]  prev_leds;
    logic [5:0]  cyc_ref;
    int          run;
    spi_sck = 1'b0;
    spi_mosi = 1'b0;
    spi_ss_n = 1'b1;
    spi_cs2 = 1'b1;
    u1004_data = 1'b0;
    hw_flags = 3'b101;
    rb_addr = '{dmm_pkg::REG_DIRECT, dmm_pkg::REG_APERTURE, dmm_pkg::REG_PRECHARGE};
    smodes  = '{3'd0, 3'd1, 3'd2, 3'd5, 3'd6, 3'd7};
    @(posedge arst_n);
    @(negedge clk);

    // reset state, pins low, oe low, status word
    static_chk = 1'b1;
    repeat (4) @(negedge clk);
    static_chk = 1'b0;
    check_equal(g_oe, 1'b0, "4094 oe after reset");
    spi_xfer(dmm_pkg::REG_STATUS, '0, rd);
    check_equal(rd, {21'd0, hw_flags, 8'hAA}, "status after reset");
    rng_state = lcg_next(rng_state);
    spi_xfer(dmm_pkg::REG_STATUS, rng_state, rd);  // write is dropped
    spi_xfer(dmm_pkg::REG_STATUS, '0, rd);
    check_equal(rd, {21'd0, hw_flags, 8'hAA}, "status after write attempt");

    // sequencer, precharge 3 and aperture 5
    write_reg(dmm_pkg::REG_PRECHARGE, 32'd3);
    write_reg(dmm_pkg::REG_APERTURE, 32'd5);
    write_reg(dmm_pkg::REG_MODE, 32'd4);
    pc1 = 1'b1;
    while (pc1) sa_sample(pc1, led);
    while (!pc1) sa_sample(pc1, led);  // now on first sample cycle
    for (int p = 0; p < 3; p++) begin
      run = 1;
      led_ref = led;
      cyc_ref = monitor[7:2];
      sa_sample(pc1, led);
      while (pc1) begin
        run++;
        check_equal(led, led_ref, "led steady during sample");
        sa_sample(pc1, led);
      end
      check_equal(run, 5, "sample phase length");
      check_equal(led, !led_ref, "led toggle at end of sample");
      check_equal(monitor[7:2], 6'(cyc_ref + 6'd1), "period count on monitor");
      run = 1;
      led_ref = led;
      sa_sample(pc1, led);
      while (!pc1) begin
        run++;
        check_equal(led, led_ref, "led steady during precharge");
        sa_sample(pc1, led);
      end
      check_equal(run, 3, "precharge phase length");
    end

    // read-back returns the previous value
    rb_prev = '{32'd0, 32'd5, 32'd3};
    for (int k = 0; k < 3; k++) begin
      for (int j = 0; j < 3; j++) begin
        rng_state = lcg_next(rng_state);
        spi_xfer(rb_addr[j], rng_state, rd);
        check_equal(rd, rb_prev[j], "register read-back");
        rb_prev[j] = rng_state;
      end
    end

    // static modes with random direct words
    for (int m = 0; m < 6; m++) begin
      model_mode = smodes[m];
      write_reg(dmm_pkg::REG_MODE, {29'd0, smodes[m]});
      for (int k = 0; k < 2; k++) begin
        rng_state = lcg_next(rng_state);
        w = rng_state;
        model_direct = w;
        write_reg(dmm_pkg::REG_DIRECT, w);
        static_chk = 1'b1;
        repeat (10) @(negedge clk);
        static_chk = 1'b0;
      end
    end

    // test pattern, leds step by one each clock
    write_reg(dmm_pkg::REG_MODE, 32'd3);
    prev_leds = leds;
    repeat (32) begin
      @(negedge clk);
      check_equal(leds, 4'(prev_leds + 4'd1), "pattern step");
      prev_leds = leds;
    end

    // 4094 routing on, then off, then oe
    write_reg(dmm_pkg::REG_SPI_MUX, 32'd1);
    spi_cs2 = 1'b0;
    for (int c = 0; c < 4; c++) route_check(c[0], c[1], ~c[0], 1'b1);
    route_check(1'b0, 1'b0, 1'b0, 1'b1);
    spi_cs2 = 1'b1;
    write_reg(dmm_pkg::REG_SPI_MUX, 32'd0);
    spi_cs2 = 1'b0;
    for (int c = 0; c < 4; c++) route_check(c[0], c[1], 1'b1, 1'b0);
    route_check(1'b0, 1'b0, 1'b0, 1'b0);
    spi_cs2 = 1'b1;
    check_equal(g_oe, 1'b0, "4094 oe before write");
    write_reg(dmm_pkg::REG_4094, 32'd1);
    check_equal(g_oe, 1'b1, "4094 oe after write");

    finish_run(1'b0);
  end

endmodule

// ==== dmm.f ====
src/dmm_pkg.sv
src/spi_regs.sv
src/spi_route.sv
src/sa_timer.sv
src/sa_fsm.sv
src/output_mode.sv
src/dmm_top.sv
test/tb_clock.sv
test/tb_dmm.sv

// ==== run.sh ====
#!/bin/sh
# compile with Verilator, run, and look for the pass line in the output
verilator --binary --timing --assert -Wno-fatal -f dmm.f --top-module tb_dmm -o tb_dmm \
  && ./obj_dir/tb_dmm | tee /dev/stderr | grep "Everything OK" > /dev/null \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }
